// ==== rtl/vec_pkg.sv ====
`default_nettype none

package vec_pkg;

	// One vector element
	typedef logic [31:0] data_t;

	// Local memory word address, also used for length and stride
	typedef logic [15:0] address_t;

	// Four vector registers
	typedef logic [1:0] vreg_idx_t;

	typedef enum logic {
		op_load  = 1'b0,	// Memory to register
		op_store = 1'b1		// Register to memory
	} access_op_t;

	// One strided access command from the host
	typedef struct packed {
		access_op_t op;			// Load or store
		vreg_idx_t  vreg;		// Source or target register
		address_t   length;		// Element count, 1 to vlen
		address_t   stride;		// Word distance between elements
		address_t   base_addr;	// Address of element zero
	} access_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/dmem_pkg.sv ====
`default_nettype none

package dmem_pkg;

	import vec_pkg::*;

	// Request from the access engine to local memory
	typedef struct packed {
		logic     we;		// Write when set, read otherwise
		address_t addr;		// Already reduced modulo memory depth
		data_t    wdata;	// Store element
	} mem_req_t;

	// Access engine FSM
	typedef enum logic [1:0] {
		idle      = 2'd0,	// Waiting for a request level
		store_run = 2'd1,	// Issuing store elements
		load_run  = 2'd2,	// Issuing load reads
		finish    = 2'd3	// One cycle after the end pulse
	} engine_state_t;

endpackage

`default_nettype wire

// ==== rtl/load_store_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_store_unit
	import vec_pkg::*;
(
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        cmd_valid,		// Host command strobe
	input  wire access_cmd_t cmd,			// Host command
	input  wire logic        stall,			// Freezes issue
	input  wire logic        st_ready,		// Store element accepted by engine
	input  wire logic        ld_ready,		// Load element valid on ld_rdata
	input  wire logic        st_end_access,	// Last store write
	input  wire logic        ld_end_access,	// Last load element
	input  wire data_t       st_elem,		// Current element from register file
	input  wire data_t       ld_rdata,		// Memory read data
	output      logic        st_req,		// Store active level
	output      logic        ld_req,		// Load active level
	output      address_t    cfg_length,
	output      address_t    cfg_stride,
	output      address_t    cfg_base,
	output      logic        st_rd_rf,		// Advance store read index
	output      logic        ld_wr_rf,		// Write and advance load index
	output      data_t       st_data,		// Registered store element
	output      data_t       ld_data,		// Registered load element
	output      logic        st_end,
	output      logic        ld_end
);

	logic run;			// Command latched and not yet ended
	logic st_active;
	logic ld_active;
	logic accept;		// New command taken this cycle

	assign accept   = cmd_valid & ~run;
	assign st_req   = st_active;
	assign ld_req   = ld_active;
	assign st_rd_rf = st_active & ~stall & st_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			run <= 1'b0;
		end else if (st_end_access | ld_end_access) begin
			run <= 1'b0;
		end else if (accept) begin
			run <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			st_active <= 1'b0;
		end else if (st_end_access) begin
			st_active <= 1'b0;
		end else if (accept && cmd.op == op_store) begin
			st_active <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ld_active <= 1'b0;
		end else if (ld_end_access) begin
			ld_active <= 1'b0;
		end else if (accept && cmd.op == op_load) begin
			ld_active <= 1'b1;
		end
	end

	// Configuration held for the whole access
	always_ff @(posedge clock) begin
		if (reset) begin
			cfg_length <= '0;
			cfg_stride <= '0;
			cfg_base   <= '0;
		end else if (accept) begin
			cfg_length <= cmd.length;
			cfg_stride <= cmd.stride;
			cfg_base   <= cmd.base_addr;
		end
	end

	// End pulses trail the engine flags by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			st_end   <= 1'b0;
			ld_end   <= 1'b0;
			ld_wr_rf <= 1'b0;
		end else begin
			st_end   <= st_end_access;
			ld_end   <= ld_end_access;
			ld_wr_rf <= ld_active & ld_ready;	// Not gated by stall
		end
	end

	always_ff @(posedge clock) begin
		if (st_rd_rf) begin
			st_data <= st_elem;
		end
		if (ld_ready) begin
			ld_data <= ld_rdata;
		end
	end

	assert property (@(posedge clock) disable iff (reset) !(st_req && ld_req));

	// Host must wait for the end pulse before the next command
	assert property (@(posedge clock) disable iff (reset) cmd_valid |-> !run);

endmodule

`default_nettype wire

// ==== rtl/strided_access_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module strided_access_engine
	import vec_pkg::*, dmem_pkg::*;
#(
	parameter int mem_words = 1024
) (
	input  wire logic     clock,
	input  wire logic     reset,
	input  wire logic     stall,
	input  wire logic     st_req,
	input  wire logic     ld_req,
	input  wire address_t cfg_length,
	input  wire address_t cfg_stride,
	input  wire address_t cfg_base,
	input  wire data_t    st_data,		// Registered by the unit one cycle after st_ready
	output      logic     st_ready,
	output      logic     ld_ready,
	output      logic     st_end_access,
	output      logic     ld_end_access,
	output      logic     mem_en,
	output      mem_req_t mem_req
);

	engine_state_t state;
	address_t      issue_cnt;		// Elements issued
	address_t      done_cnt;		// Elements written or returned
	address_t      run_addr;		// Address of next issue
	address_t      wr_addr;			// Address of pending write
	address_t      next_addr;
	address_t      base_addr;
	logic [16:0]   addr_sum;
	logic          more;			// Elements left to issue
	logic          last_done;
	logic          rd_issue;
	logic          wr_pending;
	logic          rd_pending;		// Read in flight

	assign addr_sum  = {1'b0, run_addr} + {1'b0, cfg_stride};
	assign next_addr = address_t'(addr_sum % 17'(mem_words));
	assign base_addr = address_t'({1'b0, cfg_base} % 17'(mem_words));

	assign more      = issue_cnt < cfg_length;
	assign last_done = done_cnt == cfg_length - 1'b1;

	assign st_ready = (state == store_run) & st_req & ~stall & more;
	assign rd_issue = (state == load_run) & ld_req & ~stall & more;
	assign ld_ready = rd_pending;	// Memory data arrives a cycle after issue

	assign st_end_access = wr_pending & last_done;
	assign ld_end_access = rd_pending & last_done;

	// Pending write wins the port, store never reads
	assign mem_en  = wr_pending | rd_issue;
	assign mem_req = '{
		we:    wr_pending,
		addr:  wr_pending ? wr_addr : run_addr,
		wdata: st_data
	};

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= idle;
			issue_cnt  <= '0;
			done_cnt   <= '0;
			run_addr   <= '0;
			wr_pending <= 1'b0;
			rd_pending <= 1'b0;
		end else begin
			wr_pending <= st_ready;
			rd_pending <= rd_issue;
			case (state)
				idle: begin
					issue_cnt <= '0;
					done_cnt  <= '0;
					run_addr  <= base_addr;
					if (st_req) begin
						state <= store_run;
					end else if (ld_req) begin
						state <= load_run;
					end
				end
				store_run, load_run: begin
					if (st_ready | rd_issue) begin
						issue_cnt <= issue_cnt + 1'b1;
						run_addr  <= next_addr;
					end
					if (wr_pending | rd_pending) begin
						done_cnt <= done_cnt + 1'b1;
					end
					if (st_end_access | ld_end_access) begin
						state <= finish;
					end
				end
				finish: state <= idle;		// Unit has dropped its level by now
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (st_ready) begin
			wr_addr <= run_addr;	// Write goes out next cycle with st_data
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		state != idle |-> done_cnt <= cfg_length);

endmodule

`default_nettype wire

// ==== rtl/local_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module local_memory
	import vec_pkg::*, dmem_pkg::*;
#(
	parameter int mem_words = 1024
) (
	input  wire logic     clock,
	input  wire logic     mem_en,		// Access this cycle
	input  wire mem_req_t mem_req,		// Write enable, address, write data
	output      data_t    rdata			// Valid one cycle after a read
);

	localparam int aw = $clog2(mem_words);

	data_t          mem [mem_words];
	logic [aw-1:0]  idx;

	// Engine keeps the address below mem_words
	assign idx = mem_req.addr[aw-1:0];

	// Read returns the old word on a write to the same address
	always_ff @(posedge clock) begin
		if (mem_en) begin
			if (mem_req.we) begin
				mem[idx] <= mem_req.wdata;
			end
			rdata <= mem[idx];
		end
	end

	// Address wrap is done by the access engine
	assert property (@(posedge clock) mem_en |-> mem_req.addr < mem_words);

endmodule

`default_nettype wire

// ==== rtl/vector_register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module vector_register_file
	import vec_pkg::*;
#(
	parameter int vlen = 16
) (
	input  wire logic      clock,
	input  wire logic      reset,
	input  wire logic      cmd_valid,	// Clears indices, latches target
	input  wire vreg_idx_t cmd_vreg,
	input  wire logic      st_rd_rf,	// Advance store read index
	input  wire logic      ld_wr_rf,	// Write and advance load index
	input  wire data_t     ld_data,
	output      data_t     st_elem,		// Element at store read index
	input  wire logic      host_wr,
	input  wire vreg_idx_t host_vreg,
	input  wire address_t  host_elem,
	input  wire data_t     host_wdata,
	output      data_t     host_rdata
);

	localparam int ew = $clog2(vlen);

	data_t       regs [4][vlen];
	vreg_idx_t   target;			// Register of the current command
	logic [ew:0] st_idx;			// One extra bit to reach vlen
	logic [ew:0] ld_idx;

	assign st_elem    = regs[target][st_idx[ew-1:0]];
	assign host_rdata = regs[host_vreg][host_elem[ew-1:0]];

	always_ff @(posedge clock) begin
		if (reset) begin
			target <= '0;
			st_idx <= '0;
			ld_idx <= '0;
		end else if (cmd_valid) begin
			target <= cmd_vreg;
			st_idx <= '0;
			ld_idx <= '0;
		end else begin
			if (st_rd_rf) begin
				st_idx <= st_idx + 1'b1;
			end
			if (ld_wr_rf) begin
				ld_idx <= ld_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (ld_wr_rf) begin
			regs[target][ld_idx[ew-1:0]] <= ld_data;
		end
		if (host_wr) begin
			regs[host_vreg][host_elem[ew-1:0]] <= host_wdata;	// Host only writes while idle
		end
	end

	// Command length must not run past the register
	assert property (@(posedge clock) disable iff (reset) st_idx <= vlen && ld_idx <= vlen);

endmodule

`default_nettype wire

// ==== rtl/vector_lsu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vector_lsu_top
	import vec_pkg::*, dmem_pkg::*;
#(
	parameter int mem_words = 1024,
	parameter int vlen      = 16
) (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic        cmd_valid,
	input  wire access_cmd_t cmd,
	input  wire logic        stall,
	input  wire logic        host_wr,
	input  wire vreg_idx_t   host_vreg,
	input  wire address_t    host_elem,
	input  wire data_t       host_wdata,
	output      data_t       host_rdata,
	output      logic        st_end,
	output      logic        ld_end
);

	logic     st_req, ld_req;
	logic     st_ready, ld_ready;
	logic     st_end_access, ld_end_access;
	logic     st_rd_rf, ld_wr_rf;
	address_t cfg_length, cfg_stride, cfg_base;
	data_t    st_elem, st_data, ld_data, mem_rdata;
	logic     mem_en;
	mem_req_t mem_req;

	load_store_unit u_lsu (
		.clock, .reset, .cmd_valid, .cmd, .stall,
		.st_ready, .ld_ready, .st_end_access, .ld_end_access,
		.st_elem, .ld_rdata(mem_rdata),
		.st_req, .ld_req, .cfg_length, .cfg_stride, .cfg_base,
		.st_rd_rf, .ld_wr_rf, .st_data, .ld_data, .st_end, .ld_end
	);

	strided_access_engine #(.mem_words(mem_words)) u_engine (
		.clock, .reset, .stall, .st_req, .ld_req,
		.cfg_length, .cfg_stride, .cfg_base, .st_data,
		.st_ready, .ld_ready, .st_end_access, .ld_end_access,
		.mem_en, .mem_req
	);

	local_memory #(.mem_words(mem_words)) u_mem (
		.clock, .mem_en, .mem_req, .rdata(mem_rdata)
	);

	vector_register_file #(.vlen(vlen)) u_vrf (
		.clock, .reset, .cmd_valid, .cmd_vreg(cmd.vreg),
		.st_rd_rf, .ld_wr_rf, .ld_data, .st_elem,
		.host_wr, .host_vreg, .host_elem, .host_wdata, .host_rdata
	);

endmodule

`default_nettype wire

// ==== test/tb_vector_lsu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_vector_lsu
	import vec_pkg::*;
();

	localparam int mem_words   = 1024;
	localparam int vlen        = 16;
	localparam int n_rand      = 12;						// Random store and load pairs
	localparam int n_cmds      = 10 + 2 * n_rand + 2;
	localparam int cycle_limit = n_cmds * 200 + 2000;

	logic clock, reset, cmd_valid, stall, host_wr, st_end, ld_end;
	access_cmd_t cmd;
	vreg_idx_t host_vreg;
	address_t host_elem;
	data_t host_wdata, host_rdata;

	data_t model_mem [mem_words];
	bit mem_known [mem_words];							// Word written by a store
	data_t model_reg [4][vlen];
	bit reg_known [4][vlen];
	logic [31:0] rng, stall_rng;
	bit stall_en;
	int cycle, tests, errors, test_errs, st_pulses, ld_pulses, i;

	vector_lsu_top #(.mem_words(mem_words), .vlen(vlen)) i_dut (
		.clock, .reset, .cmd_valid, .cmd, .stall, .host_wr, .host_vreg, .host_elem,
		.host_wdata, .host_rdata, .st_end, .ld_end
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("Run stopped after %0d cycles, commands did not complete", cycle);
			$display("Finished with errors");
			$finish;
		end
	end

	always @(negedge clock) begin							// End pulse counter
		if (st_end) st_pulses++;
		if (ld_end) ld_pulses++;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int rand_below(input int range);
		rng = lcg_next(rng);
		return int'(rng[30:8]) % range;
	endfunction

	// Expected effect of one command on model memory and registers
	function automatic void apply_ref(input access_cmd_t c);
		int k;
		int addr;
		for (k = 0; k < int'(c.length); k++) begin
			addr = (int'(c.base_addr) + k * int'(c.stride)) % mem_words;
			if (c.op == op_store) begin
				model_mem[addr] = model_reg[c.vreg][k];
				mem_known[addr] = reg_known[c.vreg][k];
			end else begin
				model_reg[c.vreg][k] = model_mem[addr];
				reg_known[c.vreg][k] = mem_known[addr];
			end
		end
	endfunction

	task automatic next_cycle();
		@(posedge clock);
		#1;
		if (stall_en) begin
			stall_rng = lcg_next(stall_rng);
			stall = stall_rng[23:21] < 3'd3;				// Roughly 40 percent
		end else begin
			stall = 1'b0;
		end
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			test_errs++;
		end
	endtask

	task automatic check_end(input string name, input int exp_lat, input int lat,
			input int pulses, input int stray);
		if (lat < 0) begin
			$display("%s: the end pulse never arrived within 200 cycles", name);
			test_errs++;
		end else begin
			if (exp_lat >= 0 && lat != exp_lat) begin
				$display("error %s latency: expected %0d, actual %0d", name, exp_lat, lat);
				test_errs++;
			end
			if (pulses != 1) begin
				$display("error %s end pulses: expected 1, actual %0d", name, pulses);
				test_errs++;
			end
			if (stray != 0) begin
				$display("%s: an end pulse of the other direction appeared", name);
				test_errs++;
			end
		end
	endtask

	task automatic run_cmd(input string name, input access_op_t op, input vreg_idx_t vreg,
			input int length, input int stride, input int base);
		access_cmd_t c;
		int lat;
		int exp_lat;
		int n;
		c = '{op: op, vreg: vreg, length: address_t'(length), stride: address_t'(stride),
			base_addr: address_t'(base)};
		exp_lat = stall_en ? -1 : length + 3;
		lat = -1;
		next_cycle();
		st_pulses = 0;
		ld_pulses = 0;
		cmd = c;
		cmd_valid = 1'b1;
		for (n = 1; n <= 200 && lat < 0; n++) begin
			next_cycle();
			cmd_valid = 1'b0;
			@(negedge clock);
			if (op == op_store ? st_end : ld_end) lat = n;
		end
		repeat (3) next_cycle();							// Lets the last load write land
		apply_ref(c);
		if (op == op_store) check_end(name, exp_lat, lat, st_pulses, ld_pulses);
		else check_end(name, exp_lat, lat, ld_pulses, st_pulses);
	endtask

	task automatic fill_reg(input vreg_idx_t r);
		int e;
		for (e = 0; e < vlen; e++) begin
			next_cycle();
			rng = lcg_next(rng);
			host_wr = 1'b1;
			host_vreg = r;
			host_elem = address_t'(e);
			host_wdata = rng;
			model_reg[r][e] = rng;
			reg_known[r][e] = 1'b1;
		end
		next_cycle();
		host_wr = 1'b0;
	endtask

	task automatic check_reg(input string name, input vreg_idx_t r);
		int e;
		for (e = 0; e < vlen; e++) begin
			next_cycle();
			host_vreg = r;
			host_elem = address_t'(e);
			@(negedge clock);
			if (reg_known[r][e]) check_data($sformatf("%s v%0d[%0d]", name, r, e),
				model_reg[r][e], host_rdata);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		errors += test_errs;
		if (test_errs == 0) $display("test %s passed", name);
		else $display("test %s failed with %0d errors", name, test_errs);
		test_errs = 0;
	endtask

	initial begin
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		stall = 1'b0;
		host_wr = 1'b0;
		host_vreg = '0;
		host_elem = '0;
		host_wdata = '0;
		rng = 32'ha925;
		stall_rng = 32'ha925;
		stall_en = 1'b0;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		for (i = 0; i < 4; i++) fill_reg(vreg_idx_t'(i));

		run_cmd("unit_stride store", op_store, 2'd0, vlen, 1, 100);
		run_cmd("unit_stride load", op_load, 2'd1, vlen, 1, 100);
		check_reg("unit_stride", 2'd1);
		end_test("unit_stride");

		run_cmd("wrap store", op_store, 2'd2, vlen, 3, mem_words - 5);	// Wraps past zero
		run_cmd("wrap load", op_load, 2'd3, vlen, 3, mem_words - 5);
		check_reg("wrap", 2'd3);
		end_test("wrap_stride3");

		run_cmd("permute store", op_store, 2'd2, vlen, 1, 200);
		run_cmd("permute load", op_load, 2'd0, vlen, 16'hffff, 215);	// Reversed order
		check_reg("permute", 2'd0);
		end_test("permute");

		run_cmd("short store 1", op_store, 2'd1, 1, 7, 500);
		run_cmd("short load 1", op_load, 2'd3, 1, 7, 500);
		run_cmd("short store 2", op_store, 2'd0, 2, 5, 600);
		run_cmd("short load 2", op_load, 2'd2, 2, 5, 600);
		check_reg("short", 2'd3);
		check_reg("short", 2'd2);
		end_test("short_lengths");

		stall_en = 1'b1;
		for (i = 0; i < n_rand; i++) begin
			automatic vreg_idx_t vs = vreg_idx_t'(rand_below(4));
			automatic vreg_idx_t vl = vreg_idx_t'(rand_below(4));
			automatic int base = 1000 + rand_below(40);
			run_cmd("random store", op_store, vs, 1 + rand_below(vlen), 1 + rand_below(4), base);
			run_cmd("random load", op_load, vl, 1 + rand_below(vlen), 1 + rand_below(4), base);
			check_reg("random", vl);
		end
		stall_en = 1'b0;
		end_test("random_stall");

		run_cmd("latency store", op_store, 2'd3, 5, 2, 700);
		run_cmd("latency load", op_load, 2'd1, 9, 1, 700);
		check_reg("latency", 2'd1);
		end_test("latency");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/vec_pkg.sv
rtl/dmem_pkg.sv
rtl/load_store_unit.sv
rtl/strided_access_engine.sv
rtl/local_memory.sv
rtl/vector_register_file.sv
rtl/vector_lsu_top.sv
test/tb_vector_lsu.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the vector load/store testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal -f all.f --top-module tb_vector_lsu -o tb_vector_lsu \
	&& ./obj_dir/tb_vector_lsu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
